//--- source/cbuf_settings.svh
// conv buffer build settings
`ifndef CBUF_SETTINGS_SVH
`define CBUF_SETTINGS_SVH

// channels per buffer word, each channel is two bytes
`define CBUF_ATOMIC_C 4

`define CBUF_BANK_N 4 // physical banks shared by both regions
`define CBUF_BANK_DEPTH 64 // words per bank

// commands a port may have in flight
`define CBUF_MAX_OUTSTANDING 2

// derived widths
`define CBUF_WORD_BYTES (`CBUF_ATOMIC_C * 2)
`define CBUF_WORD_W (`CBUF_WORD_BYTES * 8)
`define CBUF_BANK_IDX_W $clog2(`CBUF_BANK_N)
`define CBUF_ROW_W $clog2(`CBUF_BANK_DEPTH)

`endif

//--- source/cbuf_icb_pkg.sv
// ICB port types
`default_nettype none
`include "cbuf_settings.svh"

package cbuf_icb_pkg;

	typedef logic [`CBUF_WORD_W-1:0] icb_data_t; // one buffer word
	typedef logic [`CBUF_WORD_BYTES-1:0] icb_mask_t; // one bit per byte lane
	typedef logic [31:0] icb_addr_t; // byte address

	// command channel payload
	typedef struct packed {
		icb_addr_t addr;
		logic read;
		icb_data_t wdata;
		icb_mask_t wmask;
	} icb_cmd_t;

	// response channel payload
	typedef struct packed {
		icb_data_t rdata;
		logic err; // out of region
	} icb_rsp_t;

endpackage

`default_nettype wire

//--- source/cbuf_mem_pkg.sv
// bank side types
`default_nettype none
`include "cbuf_settings.svh"

package cbuf_mem_pkg;
	import cbuf_icb_pkg::*;

	typedef logic [`CBUF_BANK_IDX_W-1:0] bank_idx_t;
	typedef logic [`CBUF_ROW_W-1:0] bank_row_t;
	typedef logic [0:0] port_sel_t; // 0 feature map, 1 kernel

	// one access to a single bank
	typedef struct packed {
		logic en;
		icb_mask_t we; // byte write enables, zero on reads
		bank_row_t row;
		icb_data_t wdata;
	} bank_req_t;

	// what was issued in a cycle, used to route the response
	typedef struct packed {
		logic valid;
		port_sel_t port;
		bank_idx_t bank;
		logic read;
		logic err;
	} issue_rec_t;

endpackage

`default_nettype wire

//--- source/icb_reg_slice.sv
// registered channel slice
`timescale 1ns/1ps
`default_nettype none

module icb_reg_slice #(
	parameter int WIDTH = 32
)(
	input wire logic aclk,
	input wire logic rst,

	input wire logic [WIDTH-1:0] in_data,
	input wire logic in_valid,
	output logic in_ready,

	output logic [WIDTH-1:0] out_data,
	output logic out_valid,
	input wire logic out_ready
);

	logic [WIDTH-1:0] main_q; // entry facing the output
	logic [WIDTH-1:0] skid_q; // catches the beat taken while output stalls
	logic main_v;
	logic skid_v;
	logic in_fire;
	logic main_free;

	// ready comes straight from a flop
	assign in_ready = !skid_v;
	assign in_fire = in_valid && !skid_v;

	// main entry empties or moves on this edge
	assign main_free = !main_v || out_ready;

	assign out_data = main_q;
	assign out_valid = main_v;

	always_ff @(posedge aclk) begin
		if (rst) begin
			main_v <= 1'b0;
			skid_v <= 1'b0;
		end else if (main_free) begin
			main_v <= skid_v || in_fire; // skid first, keeps order
			skid_v <= 1'b0;
		end else if (in_fire) begin
			skid_v <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (main_free && (skid_v || in_fire))
			main_q <= skid_v ? skid_q : in_data;
		if (!main_free && in_fire)
			skid_q <= in_data;
	end

endmodule

`default_nettype wire

//--- source/cbuf_addr_map.sv
// port arbiter and bank address map
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_settings.svh"

module cbuf_addr_map
	import cbuf_icb_pkg::*;
	import cbuf_mem_pkg::*;
(
	input wire logic aclk,
	input wire logic rst,
	input wire logic [7:0] fmbufbankn, // banks given to the feature map region

	input wire icb_cmd_t fm_cmd,
	input wire logic fm_valid,
	output logic fm_ready,

	input wire icb_cmd_t k_cmd,
	input wire logic k_valid,
	output logic k_ready,

	input wire logic [1:0] rsp_taken, // one response left, per port

	output bank_req_t bank_req [`CBUF_BANK_N],
	output issue_rec_t issue
);

	localparam int WORD_SH = $clog2(`CBUF_WORD_BYTES);
	localparam int SLOT_SH = WORD_SH + `CBUF_ROW_W;
	localparam int CNT_W = $clog2(`CBUF_MAX_OUTSTANDING + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	cnt_t fm_cnt; // commands in flight
	cnt_t k_cnt;
	logic rr_q; // port favoured when both ask
	logic fm_elig;
	logic k_elig;
	logic fm_gnt;
	logic k_gnt;
	logic any_gnt;
	port_sel_t sel;
	icb_cmd_t cmd;
	icb_addr_t slot;
	logic [7:0] fm_banks;
	logic [7:0] region;
	logic in_range;
	bank_idx_t phys;
	bank_row_t row;

	assign fm_elig = fm_valid && (fm_cnt < `CBUF_MAX_OUTSTANDING);
	assign k_elig = k_valid && (k_cnt < `CBUF_MAX_OUTSTANDING);

	assign fm_gnt = fm_elig && (!k_elig || !rr_q);
	assign k_gnt = k_elig && (!fm_elig || rr_q);
	assign any_gnt = fm_gnt || k_gnt;
	assign sel = k_gnt;

	assign fm_ready = fm_gnt;
	assign k_ready = k_gnt;

	// decode of the granted command
	assign cmd = sel ? k_cmd : fm_cmd;
	assign slot = cmd.addr >> SLOT_SH; // low address bits ignored, aligned only
	assign row = cmd.addr[WORD_SH +: `CBUF_ROW_W];

	assign fm_banks = (fmbufbankn > 8'(`CBUF_BANK_N)) ? 8'(`CBUF_BANK_N) : fmbufbankn;
	assign region = sel ? 8'(`CBUF_BANK_N) - fm_banks : fm_banks;
	assign in_range = slot < icb_addr_t'(region);

	// kernel region grows down from the top bank
	assign phys = sel ? bank_idx_t'(`CBUF_BANK_N - 1) - bank_idx_t'(slot)
		: bank_idx_t'(slot);

	for (genvar b = 0; b < `CBUF_BANK_N; b++) begin : g_req
		assign bank_req[b] = '{
			en: any_gnt && in_range && (phys == bank_idx_t'(b)),
			we: cmd.read ? icb_mask_t'(0) : cmd.wmask,
			row: row,
			wdata: cmd.wdata
		};
	end

	assign issue = '{
		valid: any_gnt,
		port: sel,
		bank: phys,
		read: cmd.read,
		err: !in_range
	};

	always_ff @(posedge aclk) begin
		if (rst) begin
			fm_cnt <= '0;
			k_cnt <= '0;
			rr_q <= 1'b0;
		end else begin
			fm_cnt <= fm_cnt + cnt_t'(fm_gnt) - cnt_t'(rsp_taken[0]);
			k_cnt <= k_cnt + cnt_t'(k_gnt) - cnt_t'(rsp_taken[1]);
			if (any_gnt)
				rr_q <= !sel; // other port goes first next time
		end
	end

endmodule

`default_nettype wire

//--- source/cbuf_bank.sv
// byte maskable buffer bank
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_settings.svh"

module cbuf_bank
	import cbuf_icb_pkg::*;
	import cbuf_mem_pkg::*;
(
	input wire logic aclk,
	input wire bank_req_t req,
	output wire icb_data_t dout // valid one cycle after en
);

	localparam int LANES = $bits(icb_mask_t);

	// one narrow memory per byte lane
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic [7:0] lane_mem [`CBUF_BANK_DEPTH];
		logic [7:0] lane_q;

		always_ff @(posedge aclk) begin
			if (req.en) begin
				if (req.we[i])
					lane_mem[req.row] <= req.wdata[i*8 +: 8];
				lane_q <= lane_mem[req.row]; // old contents on a write
			end
		end

		assign dout[i*8 +: 8] = lane_q;
	end

endmodule

`default_nettype wire

//--- source/cbuf_rsp_collect.sv
// response collector and per port queues
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_settings.svh"

module cbuf_rsp_collect
	import cbuf_icb_pkg::*;
	import cbuf_mem_pkg::*;
(
	input wire logic aclk,
	input wire logic rst,

	input wire issue_rec_t issue,
	input wire icb_data_t bank_dout [`CBUF_BANK_N],

	output icb_rsp_t fm_rsp,
	output logic fm_rsp_valid,
	input wire logic fm_rsp_ready,

	output icb_rsp_t k_rsp,
	output logic k_rsp_valid,
	input wire logic k_rsp_ready,

	output logic [1:0] rsp_taken
);

	issue_rec_t issue_q; // lines up with the bank read data
	icb_rsp_t rsp_word;
	icb_rsp_t q_head [2];
	logic [1:0] q_valid;
	logic [1:0] q_ready;

	always_ff @(posedge aclk) begin
		if (rst)
			issue_q <= '0;
		else
			issue_q <= issue;
	end

	// writes and rejected commands return zero data
	assign rsp_word.rdata = (issue_q.read && !issue_q.err) ? bank_dout[issue_q.bank]
		: icb_data_t'(0);
	assign rsp_word.err = issue_q.err;

	// two entries per port, the outstanding limit keeps them from overflowing
	for (genvar p = 0; p < 2; p++) begin : g_port
		icb_rsp_t q_mem [2];
		logic [1:0] q_cnt;
		logic q_wp;
		logic q_rp;
		logic push;
		logic pop;

		assign push = issue_q.valid && (issue_q.port == port_sel_t'(p));
		assign pop = q_valid[p] && q_ready[p];

		assign q_valid[p] = (q_cnt != 2'd0);
		assign q_head[p] = q_mem[q_rp];
		assign rsp_taken[p] = pop; // frees a slot in the address map

		always_ff @(posedge aclk) begin
			if (rst) begin
				q_cnt <= 2'd0;
				q_wp <= 1'b0;
				q_rp <= 1'b0;
			end else begin
				q_cnt <= q_cnt + 2'(push) - 2'(pop);
				if (push)
					q_wp <= !q_wp;
				if (pop)
					q_rp <= !q_rp;
			end
		end

		always_ff @(posedge aclk) begin
			if (push)
				q_mem[q_wp] <= rsp_word;
		end
	end

	assign fm_rsp = q_head[0];
	assign fm_rsp_valid = q_valid[0];
	assign q_ready[0] = fm_rsp_ready;

	assign k_rsp = q_head[1];
	assign k_rsp_valid = q_valid[1];
	assign q_ready[1] = k_rsp_ready;

endmodule

`default_nettype wire

//--- source/conv_buffer_top.sv
// banked convolution buffer top
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_settings.svh"

module conv_buffer_top
	import cbuf_icb_pkg::*;
	import cbuf_mem_pkg::*;
(
	input wire logic aclk,
	input wire logic rst,
	input wire logic [7:0] fmbufbankn,

	// feature map port
	input wire icb_cmd_t fm_cmd,
	input wire logic fm_cmd_valid,
	output logic fm_cmd_ready,
	output icb_rsp_t fm_rsp,
	output logic fm_rsp_valid,
	input wire logic fm_rsp_ready,

	// kernel port
	input wire icb_cmd_t k_cmd,
	input wire logic k_cmd_valid,
	output logic k_cmd_ready,
	output icb_rsp_t k_rsp,
	output logic k_rsp_valid,
	input wire logic k_rsp_ready
);

	icb_cmd_t fm_cmd_s; // after the command slices
	logic fm_cmd_s_valid;
	logic fm_cmd_s_ready;
	icb_cmd_t k_cmd_s;
	logic k_cmd_s_valid;
	logic k_cmd_s_ready;

	icb_rsp_t fm_rsp_c; // before the response slices
	logic fm_rsp_c_valid;
	logic fm_rsp_c_ready;
	icb_rsp_t k_rsp_c;
	logic k_rsp_c_valid;
	logic k_rsp_c_ready;

	logic [1:0] rsp_taken;
	issue_rec_t issue;
	bank_req_t bank_req [`CBUF_BANK_N];
	icb_data_t bank_dout [`CBUF_BANK_N];

	icb_reg_slice #(.WIDTH($bits(icb_cmd_t))) u_fm_cmd_slice (
		.aclk(aclk), .rst(rst),
		.in_data(fm_cmd), .in_valid(fm_cmd_valid), .in_ready(fm_cmd_ready),
		.out_data(fm_cmd_s), .out_valid(fm_cmd_s_valid), .out_ready(fm_cmd_s_ready)
	);

	icb_reg_slice #(.WIDTH($bits(icb_cmd_t))) u_k_cmd_slice (
		.aclk(aclk), .rst(rst),
		.in_data(k_cmd), .in_valid(k_cmd_valid), .in_ready(k_cmd_ready),
		.out_data(k_cmd_s), .out_valid(k_cmd_s_valid), .out_ready(k_cmd_s_ready)
	);

	cbuf_addr_map u_addr_map (
		.aclk(aclk), .rst(rst), .fmbufbankn(fmbufbankn),
		.fm_cmd(fm_cmd_s), .fm_valid(fm_cmd_s_valid), .fm_ready(fm_cmd_s_ready),
		.k_cmd(k_cmd_s), .k_valid(k_cmd_s_valid), .k_ready(k_cmd_s_ready),
		.rsp_taken(rsp_taken), .bank_req(bank_req), .issue(issue)
	);

	for (genvar b = 0; b < `CBUF_BANK_N; b++) begin : g_bank
		cbuf_bank u_bank (.aclk(aclk), .req(bank_req[b]), .dout(bank_dout[b]));
	end

	cbuf_rsp_collect u_rsp_collect (
		.aclk(aclk), .rst(rst), .issue(issue), .bank_dout(bank_dout),
		.fm_rsp(fm_rsp_c), .fm_rsp_valid(fm_rsp_c_valid), .fm_rsp_ready(fm_rsp_c_ready),
		.k_rsp(k_rsp_c), .k_rsp_valid(k_rsp_c_valid), .k_rsp_ready(k_rsp_c_ready),
		.rsp_taken(rsp_taken)
	);

	icb_reg_slice #(.WIDTH($bits(icb_rsp_t))) u_fm_rsp_slice (
		.aclk(aclk), .rst(rst),
		.in_data(fm_rsp_c), .in_valid(fm_rsp_c_valid), .in_ready(fm_rsp_c_ready),
		.out_data(fm_rsp), .out_valid(fm_rsp_valid), .out_ready(fm_rsp_ready)
	);

	icb_reg_slice #(.WIDTH($bits(icb_rsp_t))) u_k_rsp_slice (
		.aclk(aclk), .rst(rst),
		.in_data(k_rsp_c), .in_valid(k_rsp_c_valid), .in_ready(k_rsp_c_ready),
		.out_data(k_rsp), .out_valid(k_rsp_valid), .out_ready(k_rsp_ready)
	);

endmodule

`default_nettype wire

//--- test/tb_conv_buffer.sv
// conv buffer testbench
`timescale 1ns/1ps
`default_nettype none
`include "cbuf_settings.svh"

module tb_conv_buffer
	import cbuf_icb_pkg::*;
();

	localparam int BANKS = `CBUF_BANK_N;
	localparam int DEPTH = `CBUF_BANK_DEPTH;
	localparam int WORD_BYTES = `CBUF_ATOMIC_C * 2;

	logic aclk;
	logic rst;
	logic [7:0] fmbufbankn;
	icb_cmd_t fm_cmd;
	logic fm_cmd_valid;
	logic fm_cmd_ready;
	icb_rsp_t fm_rsp;
	logic fm_rsp_valid;
	logic fm_rsp_ready;
	icb_cmd_t k_cmd;
	logic k_cmd_valid;
	logic k_cmd_ready;
	icb_rsp_t k_rsp;
	logic k_rsp_valid;
	logic k_rsp_ready;

	icb_data_t ref_mem [BANKS][DEPTH]; // model, physical bank by row
	icb_cmd_t fm_cmd_q [$]; // commands not yet accepted
	icb_rsp_t fm_exp_q [$]; // responses still owed, in command order
	icb_cmd_t k_cmd_q [$];
	icb_rsp_t k_exp_q [$];
	integer seed;

	initial aclk = 1'b0;
	always #4 aclk = !aclk;

	conv_buffer_top u_dut (
		.aclk(aclk), .rst(rst), .fmbufbankn(fmbufbankn),
		.fm_cmd(fm_cmd), .fm_cmd_valid(fm_cmd_valid), .fm_cmd_ready(fm_cmd_ready),
		.fm_rsp(fm_rsp), .fm_rsp_valid(fm_rsp_valid), .fm_rsp_ready(fm_rsp_ready),
		.k_cmd(k_cmd), .k_cmd_valid(k_cmd_valid), .k_cmd_ready(k_cmd_ready),
		.k_rsp(k_rsp), .k_rsp_valid(k_rsp_valid), .k_rsp_ready(k_rsp_ready)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	function automatic icb_data_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic icb_addr_t word_addr(input int slot, input int row);
		return icb_addr_t'((slot * DEPTH + row) * WORD_BYTES);
	endfunction

	// fm region grows up from bank 0 and kernel region down from the top
	function automatic bit map_word(input bit port, input icb_addr_t addr,
			output int bank, output int row);
		int word;
		int slot;
		int fm_banks;
		word = int'(addr / WORD_BYTES);
		slot = word / DEPTH;
		row = word % DEPTH;
		fm_banks = (fmbufbankn > 8'(BANKS)) ? BANKS : int'(fmbufbankn);
		if (port) begin
			bank = BANKS - 1 - slot;
			return slot < BANKS - fm_banks;
		end
		bank = slot;
		return slot < fm_banks;
	endfunction

	task automatic queue_cmd(input bit port, input bit rd, input icb_addr_t addr,
			input icb_data_t wdata, input icb_mask_t wmask);
		icb_cmd_t cmd;
		icb_rsp_t exp;
		int bank;
		int row;
		bit ok;
		cmd.addr = addr;
		cmd.read = rd;
		cmd.wdata = wdata;
		cmd.wmask = wmask;
		ok = map_word(port, addr, bank, row);
		exp.err = !ok;
		exp.rdata = '0; // writes and rejected commands
		if (ok && rd) begin
			exp.rdata = ref_mem[bank][row];
		end else if (ok) begin
			for (int i = 0; i < WORD_BYTES; i++)
				if (wmask[i])
					ref_mem[bank][row][i*8 +: 8] = wdata[i*8 +: 8];
		end
		if (port) begin
			k_cmd_q.push_back(cmd);
			k_exp_q.push_back(exp);
		end else begin
			fm_cmd_q.push_back(cmd);
			fm_exp_q.push_back(exp);
		end
	endtask

	task automatic write_word(input bit port, input int slot, input int row,
			input icb_data_t data, input icb_mask_t mask);
		queue_cmd(port, 1'b0, word_addr(slot, row), data, mask);
	endtask

	task automatic read_word(input bit port, input int slot, input int row);
		queue_cmd(port, 1'b1, word_addr(slot, row), rand_word(), 8'h00);
	endtask

	task automatic check_rsp(input bit port, input icb_rsp_t got);
		icb_rsp_t exp;
		string name;
		int owed;
		name = port ? "k_rsp" : "fm_rsp";
		owed = port ? k_exp_q.size() : fm_exp_q.size();
		assert (owed != 0) else
			stop_run($sformatf("%s delivered a response that no command asked for", name));
		if (port)
			exp = k_exp_q.pop_front();
		else
			exp = fm_exp_q.pop_front();
		assert (got.err === exp.err) else
			stop_run($sformatf("[FAIL] %s.err got 0x%h expected 0x%h", name, got.err, exp.err));
		assert (got.rdata === exp.rdata) else
			stop_run($sformatf("[FAIL] %s.rdata got 0x%h expected 0x%h",
				name, got.rdata, exp.rdata));
	endtask

	// drives both queues until every owed response is back
	task automatic run_batch(input int stall);
		int cyc;
		int limit;
		bit fm_fire;
		bit k_fire;
		limit = stall + 40 * (fm_cmd_q.size() + k_cmd_q.size()) + 50;
		cyc = 0;
		while (fm_cmd_q.size() + k_cmd_q.size() + fm_exp_q.size() + k_exp_q.size() != 0) begin
			fm_cmd_valid = (fm_cmd_q.size() != 0);
			if (fm_cmd_valid)
				fm_cmd = fm_cmd_q[0];
			k_cmd_valid = (k_cmd_q.size() != 0);
			if (k_cmd_valid)
				k_cmd = k_cmd_q[0];
			fm_rsp_ready = (cyc >= stall); // low for the first stall cycles
			k_rsp_ready = (cyc >= stall);
			fm_fire = fm_cmd_valid && fm_cmd_ready; // ready is a flop output, stable here
			k_fire = k_cmd_valid && k_cmd_ready;
			if (fm_rsp_valid && fm_rsp_ready)
				check_rsp(1'b0, fm_rsp);
			if (k_rsp_valid && k_rsp_ready)
				check_rsp(1'b1, k_rsp);
			@(negedge aclk);
			if (fm_fire)
				void'(fm_cmd_q.pop_front());
			if (k_fire)
				void'(k_cmd_q.pop_front());
			cyc++;
			assert (cyc <= limit) else
				stop_run("timed out waiting for commands to be accepted and answered");
		end
		fm_cmd_valid = 1'b0;
		k_cmd_valid = 1'b0;
		// nothing extra may show up afterwards
		for (int i = 0; i < 8; i++) begin
			@(negedge aclk);
			assert (!fm_rsp_valid && !k_rsp_valid) else
				stop_run("a response arrived after all commands were answered");
		end
	endtask

	task automatic test_reset_state();
		assert (fm_rsp_valid === 1'b0) else
			stop_run($sformatf("[FAIL] fm_rsp_valid got 0x%h expected 0x0", fm_rsp_valid));
		assert (k_rsp_valid === 1'b0) else
			stop_run($sformatf("[FAIL] k_rsp_valid got 0x%h expected 0x0", k_rsp_valid));
		assert (fm_cmd_ready === 1'b1) else
			stop_run($sformatf("[FAIL] fm_cmd_ready got 0x%h expected 0x1", fm_cmd_ready));
		assert (k_cmd_ready === 1'b1) else
			stop_run($sformatf("[FAIL] k_cmd_ready got 0x%h expected 0x1", k_cmd_ready));
	endtask

	task automatic test_full_writes();
		int fm_rows [8];
		int k_rows [8];
		fmbufbankn = 8'd2;
		for (int i = 0; i < 8; i++) begin
			fm_rows[i] = $random(seed) & (DEPTH - 1);
			k_rows[i] = $random(seed) & (DEPTH - 1);
			write_word(1'b0, i % 2, fm_rows[i], rand_word(), 8'hff);
			write_word(1'b1, i % 2, k_rows[i], rand_word(), 8'hff);
		end
		run_batch(0);
		for (int i = 0; i < 8; i++) begin
			read_word(1'b0, i % 2, fm_rows[i]);
			read_word(1'b1, i % 2, k_rows[i]);
		end
		run_batch(0);
	endtask

	task automatic test_partial_masks();
		fmbufbankn = 8'd2;
		write_word(1'b0, 1, 10, rand_word(), 8'hff);
		write_word(1'b0, 1, 10, rand_word(), 8'h5a);
		read_word(1'b0, 1, 10);
		write_word(1'b0, 1, 10, rand_word(), 8'h81);
		read_word(1'b0, 1, 10);
		write_word(1'b1, 0, 17, rand_word(), 8'hff);
		write_word(1'b1, 0, 17, rand_word(), 8'h0f);
		write_word(1'b1, 0, 17, rand_word(), 8'h00); // empty mask
		read_word(1'b1, 0, 17);
		run_batch(0);
	endtask

	task automatic test_out_of_region();
		fmbufbankn = 8'd2;
		write_word(1'b1, 1, 20, rand_word(), 8'hff); // bank 2
		write_word(1'b0, 1, 5, rand_word(), 8'hff); // bank 1
		run_batch(0);
		write_word(1'b0, 2, 20, rand_word(), 8'hff); // would land on bank 2
		read_word(1'b0, 2, 20);
		write_word(1'b1, 2, 5, rand_word(), 8'hff); // would land on bank 1
		read_word(1'b1, 3, 0);
		run_batch(0);
		read_word(1'b1, 1, 20);
		read_word(1'b0, 1, 5);
		run_batch(0);
	endtask

	task automatic test_shared_bank();
		fmbufbankn = 8'd3;
		write_word(1'b0, 2, 33, rand_word(), 8'hff); // top of the fm region is bank 2
		run_batch(0);
		fmbufbankn = 8'd2;
		read_word(1'b1, 1, 33); // bank 2 now sits in the kernel region
		run_batch(0);
	endtask

	task automatic test_backpressure();
		int stall;
		fmbufbankn = 8'd2;
		for (int i = 0; i < 6; i++) begin
			write_word(1'b0, i % 2, 40 + i, rand_word(), 8'hff);
			write_word(1'b1, i % 2, 40 + i, rand_word(), 8'hff);
		end
		run_batch(0);
		for (int i = 0; i < 6; i++) begin
			read_word(1'b0, i % 2, 40 + i);
			read_word(1'b1, (i + 1) % 2, 45 - i);
		end
		stall = 6 + ($random(seed) & 15);
		run_batch(stall);
	endtask

	initial begin
		seed = 32'h6440;
		rst = 1'b1;
		fmbufbankn = 8'd2;
		fm_cmd = '0;
		fm_cmd_valid = 1'b0;
		fm_rsp_ready = 1'b0;
		k_cmd = '0;
		k_cmd_valid = 1'b0;
		k_rsp_ready = 1'b0;
		repeat (8) @(posedge aclk);
		@(negedge aclk);
		rst = 1'b0;
		@(negedge aclk);
		test_reset_state();
		test_full_writes();
		test_partial_masks();
		test_out_of_region();
		test_shared_bank();
		test_backpressure();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/cbuf_icb_pkg.sv
source/cbuf_mem_pkg.sv
source/icb_reg_slice.sv
source/cbuf_addr_map.sv
source/cbuf_bank.sv
source/cbuf_rsp_collect.sv
source/conv_buffer_top.sv
test/tb_conv_buffer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the conv buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tb_conv_buffer \
	--Mdir obj_dir -o tb_conv_buffer_sim

# keep the log of a failing run for the search below
./obj_dir/tb_conv_buffer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation ok"
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi
